//--- design/fetch_decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_decode_if import fetch_pkg::*, la_isa_pkg::*; ();
    logic  valid;
    logic  allowin;
    inst_t inst;
    addr_t pc;
    logic  excp_adef;
    logic  br_taken;  // single cycle, when the branch enters ID
    addr_t br_target;

    modport source (
        output valid, inst, pc, excp_adef,
        input  allowin, br_taken, br_target
    );

    modport sink (
        input  valid, inst, pc, excp_adef,
        output allowin, br_taken, br_target
    );
endinterface

`default_nettype wire

//--- design/fetch_frontend.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend import fetch_pkg::*, la_isa_pkg::*; (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        mem_stall,
    input  wire                        load_en,
    input  wire [`IRAM_ADDR_BITS-1:0]  load_addr,
    input  inst_t                      load_data,
    input  wire                        flush,
    input  addr_t                      excep_entry,
    input  wire                        out_ready,
    output logic                       dec_valid,
    output addr_t                      dec_pc,
    output inst_t                      dec_inst,
    output logic                       dec_adef,
    output logic                       dec_is_branch
);
    inst_sram_if    sram_bus ();
    fetch_decode_if fd_bus ();

    if_stage if_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .sram        (sram_bus.master),
        .fd          (fd_bus.source),
        .flush       (flush),
        .excep_entry (excep_entry)
    );

    inst_ram inst_ram_i (
        .clk       (clk),
        .resetn    (resetn),
        .sram      (sram_bus.slave),
        .mem_stall (mem_stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    id_branch id_branch_i (
        .clk           (clk),
        .resetn        (resetn),
        .fd            (fd_bus.sink),
        .out_ready     (out_ready),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .dec_inst      (dec_inst),
        .dec_adef      (dec_adef),
        .dec_is_branch (dec_is_branch)
    );

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t; // byte address

    // size field of the sram-like bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } sram_size_e;

    // inst_ram response fsm
    typedef enum logic {
        IRAM_IDLE = 1'b0,
        IRAM_RESP = 1'b1 // one accepted request, data_ok this cycle
    } iram_state_e;

endpackage

`default_nettype wire

//--- design/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc value held in IF at reset
// the first request then goes to seq pc = 32'h1c000000
`define FETCH_RESET_PC 32'h1bfffffc

// instruction memory geometry
`define IRAM_DEPTH_WORDS 1024
`define IRAM_ADDR_BITS 10 // word index width

`endif

//--- design/id_branch.sv
`timescale 1ns/100ps
`default_nettype none

module id_branch import fetch_pkg::*, la_isa_pkg::*; (
    input  wire           clk,
    input  wire           resetn,
    fetch_decode_if.sink  fd,
    input  wire           out_ready,
    output logic          dec_valid,
    output addr_t         dec_pc,
    output inst_t         dec_inst,
    output logic          dec_adef,
    output logic          dec_is_branch
);
    logic     dropping;    // waiting for the branch target
    addr_t    drop_target;
    logic     fire_in;
    logic     wrong_path;
    logic     keep;
    logic     is_br;
    opcode6_t opcode;
    offs26_t  offs;

    assign opcode = fd.inst[31:26];
    assign offs   = get_offs26(fd.inst);
    assign is_br  = opcode == OP_B || opcode == OP_BL;

    assign fd.allowin = ~dec_valid | out_ready;
    assign fire_in    = fd.valid & fd.allowin;
    assign wrong_path = dropping & (fd.pc != drop_target);
    assign keep       = fire_in & ~wrong_path;

    assign fd.br_taken  = keep & is_br & ~fd.excp_adef;
    assign fd.br_target = fd.pc + {{4{offs[25]}}, offs, 2'b00}; // offs in words

    always_ff @(posedge clk) begin
        if (!resetn)
            dec_valid <= 1'b0;
        else if (keep)
            dec_valid <= 1'b1;
        else if (out_ready)
            dec_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            dec_pc        <= fd.pc;
            dec_inst      <= fd.inst;
            dec_adef      <= fd.excp_adef;
            dec_is_branch <= is_br;
        end
    end

    // skip the wrong-path word fetched behind a taken branch
    always_ff @(posedge clk) begin
        if (!resetn)
            dropping <= 1'b0;
        else if (fd.br_taken)
            dropping <= 1'b1;
        else if (keep)
            dropping <= 1'b0; // target arrived
    end

    always_ff @(posedge clk) begin
        if (fd.br_taken)
            drop_target <= fd.br_target;
    end

    // back to back pulses only when the target is itself a branch
    a_br_single: assert property (@(posedge clk) disable iff (!resetn)
        fd.br_taken |=> !fd.br_taken || fd.pc == $past(fd.br_target));

endmodule

`default_nettype wire

//--- design/if_stage.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module if_stage import fetch_pkg::*, la_isa_pkg::*; (
    input  wire             clk,
    input  wire             resetn,
    inst_sram_if.master     sram,
    fetch_decode_if.source  fd,
    input  wire             flush,
    input  addr_t           excep_entry
);
    // IF stage
    logic  if_valid;
    logic  if_inst_valid; // word already returned
    addr_t if_pc;
    logic  if_adef;
    inst_t if_ir;

    // pre-IF slot, request accepted but not yet in IF
    logic  pre_if_reqed;
    addr_t pre_if_pc;
    logic  pre_if_adef;
    logic  pre_if_ir_valid;
    inst_t pre_if_ir;

    // redirect holds
    logic  br_taken_reg;
    addr_t br_target_reg;
    logic  flush_hold;
    addr_t flush_target;

    logic  pending; // memory owes one response
    logic  cancel;  // next response is stale

    addr_t seq_pc;
    addr_t pre_pc;
    logic  pre_adef;
    logic  accept;
    logic  rsp_ok;
    logic  rsp_to_if;
    logic  rsp_to_pre;
    logic  pre_if_readygo;
    logic  if_allowin;
    logic  if_fire;
    logic  move;
    logic  pre_inst_now_valid;
    inst_t pre_inst_now;

    assign seq_pc = if_pc + 32'd4;
    assign pre_pc = flush        ? excep_entry
                  : flush_hold   ? flush_target
                  : br_taken_reg ? br_target_reg
                  : fd.br_taken  ? fd.br_target
                  : seq_pc;
    assign pre_adef = pre_pc[1:0] != 2'b00;

    assign accept     = sram.req & sram.addr_ok;
    assign rsp_ok     = sram.data_ok & ~cancel & ~flush;
    assign rsp_to_if  = rsp_ok & if_valid & ~if_inst_valid; // oldest owner first
    assign rsp_to_pre = rsp_ok & ~rsp_to_if;

    assign pre_inst_now_valid = pre_if_ir_valid | rsp_to_pre;
    assign pre_inst_now       = pre_if_ir_valid ? pre_if_ir : sram.rdata;

    assign fd.valid     = if_valid & (if_inst_valid | rsp_to_if);
    assign fd.inst      = if_inst_valid ? if_ir : sram.rdata;
    assign fd.pc        = if_pc;
    assign fd.excp_adef = if_adef;

    assign if_fire        = fd.valid & fd.allowin;
    assign if_allowin     = ~if_valid | if_fire | flush;
    assign pre_if_readygo = accept | pre_if_reqed & ~flush;
    assign move           = pre_if_readygo & if_allowin;

    // one request in pre-IF at a time, flush drops a stale one
    assign sram.req   = resetn & (~pre_if_reqed | flush);
    assign sram.addr  = pre_pc;
    assign sram.wr    = 1'b0;
    assign sram.size  = SIZE_WORD;
    assign sram.wstrb = 4'b0;
    assign sram.wdata = '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid      <= 1'b0;
            if_inst_valid <= 1'b0;
            if_pc         <= `FETCH_RESET_PC;
            if_adef       <= 1'b0;
        end else if (move) begin
            if_valid      <= 1'b1;
            if_inst_valid <= pre_if_reqed & ~flush & pre_inst_now_valid;
            if_pc         <= (pre_if_reqed & ~flush) ? pre_if_pc : pre_pc;
            if_adef       <= (pre_if_reqed & ~flush) ? pre_if_adef : pre_adef;
        end else if (if_fire | flush) begin
            if_valid      <= 1'b0;
            if_inst_valid <= 1'b0;
        end else if (rsp_to_if) begin
            if_inst_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (move & pre_if_reqed & ~flush)
            if_ir <= pre_inst_now;
        else if (rsp_to_if)
            if_ir <= sram.rdata; // IF blocked, keep the word
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            pre_if_reqed <= 1'b0;
        else if (flush | move)
            pre_if_reqed <= 1'b0;
        else if (accept)
            pre_if_reqed <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pre_if_pc   <= pre_pc;
            pre_if_adef <= pre_adef;
        end
        if (rsp_to_pre)
            pre_if_ir <= sram.rdata;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            pre_if_ir_valid <= 1'b0;
        else if (flush | move)
            pre_if_ir_valid <= 1'b0;
        else if (rsp_to_pre)
            pre_if_ir_valid <= 1'b1;
    end

    // branch target waits for the next accepted request
    always_ff @(posedge clk) begin
        if (!resetn)
            br_taken_reg <= 1'b0;
        else if (flush | accept)
            br_taken_reg <= 1'b0;
        else if (fd.br_taken)
            br_taken_reg <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fd.br_taken & ~accept)
            br_target_reg <= fd.br_target;
        if (flush)
            flush_target <= excep_entry;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            flush_hold <= 1'b0;
        else if (accept)
            flush_hold <= 1'b0;
        else if (flush)
            flush_hold <= 1'b1;
    end

    // responses in flight across a flush are dropped
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
            cancel  <= 1'b0;
        end else begin
            if (accept)
                pending <= 1'b1;
            else if (sram.data_ok)
                pending <= 1'b0;
            if (flush)
                cancel <= pending & ~sram.data_ok;
            else if (sram.data_ok)
                cancel <= 1'b0;
        end
    end

    a_no_req_in_reset: assert property (@(posedge clk) !resetn |-> !sram.req);

    a_valid_held: assert property (@(posedge clk) disable iff (!resetn)
        fd.valid && !fd.allowin && !flush |=> fd.valid);

endmodule

`default_nettype wire

//--- design/inst_ram.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module inst_ram import fetch_pkg::*, la_isa_pkg::*; (
    input  wire                        clk,
    input  wire                        resetn,
    inst_sram_if.slave                 sram,
    input  wire                        mem_stall,
    input  wire                        load_en,
    input  wire [`IRAM_ADDR_BITS-1:0]  load_addr,
    input  inst_t                      load_data
);
    inst_t       mem [0:`IRAM_DEPTH_WORDS-1];
    iram_state_e state;
    inst_t       rdata_q;
    logic        accept;
    logic [`IRAM_ADDR_BITS-1:0] word_idx;

    assign word_idx = sram.addr[`IRAM_ADDR_BITS+1:2]; // low two bits ignored

    // a pending response always completes this cycle, so only the stall blocks
    assign sram.addr_ok = ~mem_stall;
    assign accept       = sram.req & sram.addr_ok & ~sram.wr;
    assign sram.data_ok = state == IRAM_RESP;
    assign sram.rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= IRAM_IDLE;
        else if (accept)
            state <= IRAM_RESP;
        else
            state <= IRAM_IDLE;
    end

    always_ff @(posedge clk) begin
        if (accept)
            rdata_q <= mem[word_idx];
    end

    // preload port writes while the core is held in reset
    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    a_data_ok_after_accept: assert property (@(posedge clk) disable iff (!resetn)
        sram.data_ok |-> $past(sram.req && sram.addr_ok));

endmodule

`default_nettype wire

//--- design/inst_sram_if.sv
`timescale 1ns/100ps
`default_nettype none

interface inst_sram_if import fetch_pkg::*, la_isa_pkg::*; ();
    logic       req;
    logic       wr;
    sram_size_e size;
    logic [3:0] wstrb;
    addr_t      addr;
    inst_t      wdata;
    logic       addr_ok; // request accepted when high with req
    logic       data_ok; // one cycle after acceptance
    inst_t      rdata;

    modport master (
        output req, wr, size, wstrb, addr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, wr, size, wstrb, addr, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

`default_nettype wire

//--- design/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

    typedef logic [31:0] inst_t;    // one instruction word
    typedef logic [5:0]  opcode6_t; // inst[31:26]
    typedef logic [25:0] offs26_t;  // branch offset in words

    // unconditional direct branches
    typedef enum opcode6_t {
        OP_B  = 6'b010100,
        OP_BL = 6'b010101
    } br_op_e;

    // B/BL keep offs[15:0] in inst[25:10] and offs[25:16] in inst[9:0]
    function automatic offs26_t get_offs26(inst_t inst);
        return {inst[9:0], inst[25:10]};
    endfunction

endpackage

`default_nettype wire

//--- flist.f
+incdir+design
design/la_isa_pkg.sv
design/fetch_pkg.sv
design/inst_sram_if.sv
design/fetch_decode_if.sv
design/if_stage.sv
design/inst_ram.sv
design/id_branch.sv
design/fetch_frontend.sv
sim/tb_fetch_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch front end testbench with Verilator, run it, and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_fetch_frontend -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend 2>&1 | tee sim.log \
    && grep -q "^TEST RESULT: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_fetch_frontend.sv
`include "fetch_settings.svh"
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend import fetch_pkg::*, la_isa_pkg::*; ();
    localparam int TOTAL_OUTPUTS  = 400;
    localparam int TIMEOUT_CYCLES = `IRAM_DEPTH_WORDS + 10 + TOTAL_OUTPUTS * 20;
    localparam addr_t START_PC    = 32'h1c000000;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  adef;
        logic  br;
    } exp_t;

    logic clk;
    logic resetn;
    logic mem_stall;
    logic load_en;
    logic [`IRAM_ADDR_BITS-1:0] load_addr;
    inst_t load_data;
    logic flush;
    addr_t excep_entry;
    logic out_ready;
    logic dec_valid;
    addr_t dec_pc;
    inst_t dec_inst;
    logic dec_adef;
    logic dec_is_branch;

    inst_t prog [0:`IRAM_DEPTH_WORDS-1]; // program image and model memory
    exp_t  exp_q [$];
    addr_t model_pc;
    logic  last_taken_br; // last delivered word redirected fetch
    string test_name;
    int    out_count;
    int    cycle_cnt;
    int    hold_cnt;
    int    addr_errs;
    int    inst_errs;
    int    flag_errs;
    int    other_errs;

    fetch_frontend dut_i (
        .clk           (clk),
        .resetn        (resetn),
        .mem_stall     (mem_stall),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .flush         (flush),
        .excep_entry   (excep_entry),
        .out_ready     (out_ready),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .dec_inst      (dec_inst),
        .dec_adef      (dec_adef),
        .dec_is_branch (dec_is_branch)
    );

    always #20 clk = ~clk;

    // B is 6'b010100 and BL is 6'b010101
    function automatic logic is_branch_op(inst_t w);
        return w[31:26] == 6'b010100 || w[31:26] == 6'b010101;
    endfunction

    // offs[15:0] sits in bits 25:10 and offs[25:16] in bits 9:0
    function automatic inst_t encode_branch(logic bl, int words);
        logic [25:0] o;
        o = words[25:0];
        return {(bl ? 6'b010101 : 6'b010100), o[15:0], o[25:16]};
    endfunction

    function automatic addr_t branch_dest(addr_t pc, inst_t w);
        logic [25:0] offs;
        logic [31:0] delta;
        offs  = {w[9:0], w[25:10]};
        delta = {{6{offs[25]}}, offs} << 2; // words to bytes
        return pc + delta;
    endfunction

    task automatic build_program();
        int    k;
        inst_t w;
        for (int i = 0; i < `IRAM_DEPTH_WORDS; i++) begin
            if ($urandom % 8 == 0) begin
                k = 2 + int'($urandom % 7); // offset 1 would equal the wrong-path pc
                if ($urandom % 4 == 0)
                    k = -k;
                if (i + k < 0 || i + k >= `IRAM_DEPTH_WORDS)
                    k = -k;
                prog[i] = encode_branch($urandom % 2 == 1, k);
            end else begin
                w = $urandom;
                if (is_branch_op(w))
                    w[29] = ~w[29];
                prog[i] = w;
            end
        end
    endtask

    task automatic predict_one();
        exp_t e;
        e.pc   = model_pc;
        e.inst = prog[model_pc[`IRAM_ADDR_BITS+1:2]];
        e.adef = model_pc[1:0] != 2'b00;
        e.br   = is_branch_op(e.inst);
        exp_q.push_back(e);
        if (e.br && !e.adef)
            model_pc = branch_dest(model_pc, e.inst);
        else
            model_pc = model_pc + 32'd4;
    endtask

    task automatic check_addr(string what, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            addr_errs++;
        end
    endtask

    task automatic check_inst(string what, inst_t exp, inst_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
            inst_errs++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
            flag_errs++;
        end
    endtask

    always @(posedge clk) begin : monitor
        exp_t e;
        if (resetn && dec_valid && out_ready) begin
            if (exp_q.size() == 0)
                predict_one();
            e = exp_q.pop_front();
            check_addr("dec_pc", e.pc, dec_pc);
            check_inst("dec_inst", e.inst, dec_inst);
            check_flag("dec_adef", e.adef, dec_adef);
            check_flag("dec_is_branch", e.br, dec_is_branch);
            last_taken_br = e.br && !e.adef;
            out_count++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: %0d outputs taken after %0d cycles", out_count, cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic step_random();
        idle_cycle();
        mem_stall = ($urandom % 10) < 7;
        if (hold_cnt > 0) begin
            hold_cnt--;
        end else begin
            out_ready = ($urandom % 10) < 7;
            if (!out_ready)
                hold_cnt = $urandom % 5; // low stretch
        end
    endtask

    task automatic run_stream(string name, int n);
        int target;
        test_name = name;
        target    = out_count + n;
        while (out_count < target)
            step_random();
    endtask

    // stop fetching, empty IF and ID, and leave ID out of its drop state
    task automatic drain_pipeline();
        hold_cnt  = 0;
        out_ready = 1'b1;
        mem_stall = 1'b1;
        repeat (8) idle_cycle();
        while (last_taken_br) begin
            mem_stall = 1'b0; // one slot for the branch target
            idle_cycle();
            mem_stall = 1'b1;
            repeat (8) idle_cycle();
        end
    endtask

    task automatic pulse_flush(addr_t entry);
        if (dec_valid) begin
            $display("flush issued while an output was still waiting in ID");
            other_errs++;
        end
        flush       = 1'b1;
        excep_entry = entry;
        model_pc    = entry;
        exp_q.delete();
        idle_cycle();
        flush = 1'b0;
    endtask

    initial begin : main
        int unsigned seed_ret;
        addr_t entry;
        clk = 1'b0;
        resetn = 1'b0;
        mem_stall = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        flush = 1'b0;
        excep_entry = '0;
        out_ready = 1'b0;
        model_pc = START_PC;
        last_taken_br = 1'b0;
        seed_ret = $urandom(32'h02ecb440);
        build_program();
        for (int i = 0; i < `IRAM_DEPTH_WORDS; i++) begin
            idle_cycle();
            load_en   = 1'b1;
            load_addr = `IRAM_ADDR_BITS'(i);
            load_data = prog[i];
        end
        idle_cycle();
        load_en = 1'b0;
        repeat (10) @(posedge clk); // reset held after the preload
        #2;
        resetn = 1'b1;

        run_stream("random_stream", 150);
        drain_pipeline();
        entry = START_PC + 32'($urandom % 512 * 4);
        pulse_flush(entry);
        run_stream("flush_entry", 150);
        drain_pipeline();
        entry = START_PC + 32'($urandom % 512 * 4) + 32'(1 + $urandom % 3);
        pulse_flush(entry);
        run_stream("flush_adef", 40);
        drain_pipeline();
        entry = START_PC + 32'($urandom % 512 * 4);
        pulse_flush(entry);
        run_stream("after_adef", 60);
        drain_pipeline();

        $display("errors: pc %0d, inst %0d, flag %0d, other %0d in %0d outputs",
                 addr_errs, inst_errs, flag_errs, other_errs, out_count);
        if (addr_errs + inst_errs + flag_errs + other_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
